// File: all.f
rtl/mem_port_pkg.sv
rtl/inst_fetch_unit.sv
rtl/data_request_queue.sv
rtl/mem_bus_arbiter.sv
rtl/mem_port_top.sv
tests/tb_memory_model.sv
tests/mem_port_tb.sv

// File: Makefile
# Verilator flow for the memory port testbench
TOP := mem_port_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f all.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f all.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) > sim.log 2>&1 || true
	cat sim.log
	grep -q -F '*** PASSED ***' sim.log

clean:
	rm -rf obj_dir sim.log

// File: tests/mem_port_tb.sv
`timescale 1ns/1ps

module mem_port_tb
  import mem_port_pkg::*;
();

  logic                  clock = 1'b0;
  logic                  rst;
  mem_req_t              mem_req;
  logic [tag_width-1:0]  mem_response;
  mem_ret_t              mem_ret;
  logic                  redirect_valid;
  logic [addr_width-1:0] redirect_pc;
  logic                  fetch_valid;
  fetch_bundle_t         fetch_bundle;
  logic                  fetch_ready;
  logic                  data_req_valid;
  data_req_t             data_req;
  logic                  data_req_ready;
  logic                  load_done;
  load_result_t          load_result;

  int                     errors [1:6];
  int                     checks [1:6];
  int                     cycles = 0;
  int                     cycle_limit = 4000;   // Roughly five times the full run
  integer                 seed = 94;
  int                     bundles;
  logic [addr_width-1:0]  exp_pc;
  logic                   after_redirect;
  logic                   hold_prev;
  fetch_bundle_t          bundle_prev;
  data_req_t              pending_q [$];      // Mirror of the request FIFO
  logic                   exp_ready;          // FIFO not full after this edge
  int                     loads_in_flight;
  logic [2**id_width-1:0] id_open;
  logic [2**id_width-1:0] from_store;
  logic [data_width-1:0]  exp_data [2**id_width];
  logic [data_width-1:0]  shadow [logic [addr_width-1:0]];
  logic [id_width-1:0]    next_id;

  mem_port_top mem_port_top_inst (
    .clock          (clock),
    .rst            (rst),
    .mem_req        (mem_req),
    .mem_response   (mem_response),
    .mem_ret        (mem_ret),
    .redirect_valid (redirect_valid),
    .redirect_pc    (redirect_pc),
    .fetch_valid    (fetch_valid),
    .fetch_bundle   (fetch_bundle),
    .fetch_ready    (fetch_ready),
    .data_req_valid (data_req_valid),
    .data_req       (data_req),
    .data_req_ready (data_req_ready),
    .load_done      (load_done),
    .load_result    (load_result)
  );

  tb_memory_model memory_model (
    .clock        (clock),
    .rst          (rst),
    .mem_req      (mem_req),
    .mem_response (mem_response),
    .mem_ret      (mem_ret)
  );

  always #10 clock = ~clock;

  function automatic string test_name(input int k);
    case (k)
      1:       return "sequential_fetch";
      2:       return "back_pressure";
      3:       return "redirect";
      4:       return "data_priority";
      5:       return "loads_by_tag";
      default: return "store_then_load";
    endcase
  endfunction

  function automatic logic [data_width-1:0] expected_read(input logic [addr_width-1:0] addr);
    if (shadow.exists(addr))
      return shadow[addr];
    return addr ^ 64'hA5A5_0000_5A5A_0000;   // Never written
  endfunction

  // Data lives above 4 GiB and fetch far below
  function automatic logic is_data_addr(input logic [addr_width-1:0] addr);
    return addr[32];
  endfunction

  function automatic logic [addr_width-1:0] random_data_addr();
    return 64'h1_0000_0000 + 64'(($random(seed) & 32'h3F) * 8);
  endfunction

  task automatic report_error(input int k, input string what,
                              input logic [63:0] expected, input logic [63:0] actual);
    errors[k]++;
    $display("[ERROR] %s %s: expected %h, actual %h", test_name(k), what, expected, actual);
  endtask

  task automatic report_failure(input int k, input string what);
    errors[k]++;
    $display("Check failed in %s: %s", test_name(k), what);
  endtask

  task automatic finish_test(input int k);
    if (checks[k] == 0)
      $display("test %0d %s: no check was reached", k, test_name(k));
    else
      $display("test %0d %s: %0d checks, %0d errors", k, test_name(k), checks[k], errors[k]);
  endtask

  task automatic wait_bundles(input int target);
    while (bundles < target)
      @(negedge clock);
  endtask

  task automatic wait_data_idle();
    while (pending_q.size() != 0 || id_open != '0)
      @(negedge clock);
  endtask

  task automatic push_request(input logic is_store, input logic [addr_width-1:0] addr,
                              input logic [data_width-1:0] wdata);
    while (!data_req_ready)
      @(negedge clock);
    data_req_valid    = 1'b1;
    data_req.is_store = is_store;
    data_req.id       = next_id;
    data_req.addr     = addr;
    data_req.wdata    = wdata;
    next_id           = next_id + 4'd1;
    @(negedge clock);
    data_req_valid = 1'b0;
  endtask

  ////////////////////////////////////////////////////////////
  // Checking at the rising edge
  ////////////////////////////////////////////////////////////

  always @(posedge clock)
  begin
    int                    k;
    logic [data_width-1:0] exp_word;
    if (rst)
    begin
      exp_pc          = reset_pc;
      after_redirect  = 1'b0;
      hold_prev       = 1'b0;
      bundles         = 0;
      loads_in_flight = 0;
      id_open         = '0;
      exp_ready       = 1'b0;
      pending_q.delete();
    end
    else
    begin
      if (hold_prev)
      begin
        checks[2]++;
        assert (fetch_valid && fetch_bundle == bundle_prev)
        else report_failure(2, "bundle changed while the consumer stalled");
      end
      if (fetch_valid && !fetch_ready)
      begin
        checks[2]++;
        assert (!(mem_req.cmd == bus_load && !is_data_addr(mem_req.addr)))
        else report_failure(2, "a new fetch went out while a bundle was held");
      end
      if (fetch_valid && fetch_ready)
      begin
        k = after_redirect ? 3 : 1;
        exp_word = expected_read(exp_pc);
        checks[k]++;
        assert (fetch_bundle.pc == exp_pc)
        else report_error(k, "bundle pc", exp_pc, fetch_bundle.pc);
        checks[1] += 2;
        assert (fetch_bundle.word.dword == exp_word)
        else report_error(1, "bundle word", exp_word, fetch_bundle.word.dword);
        assert (fetch_bundle.word.inst[0] == exp_word[31:0] &&
                fetch_bundle.word.inst[1] == exp_word[63:32])
        else report_error(1, "instruction pair", exp_word,
                          {fetch_bundle.word.inst[1], fetch_bundle.word.inst[0]});
        exp_pc = exp_pc + 64'd8;
        bundles++;
      end
      if (redirect_valid)
      begin
        exp_pc         = redirect_pc;
        after_redirect = 1'b1;
      end

      if (data_req_valid || pending_q.size() != 0)
      begin
        checks[5]++;
        assert (data_req_ready == exp_ready)
        else report_error(5, "data_req_ready", 64'(exp_ready), 64'(data_req_ready));
      end

      // Issuable head must be on the bus
      if (pending_q.size() > 0 && (pending_q[0].is_store || loads_in_flight < load_slots))
      begin
        checks[4]++;
        assert (mem_req.cmd != bus_none && mem_req.addr == pending_q[0].addr)
        else report_error(4, "bus address", pending_q[0].addr, mem_req.addr);
      end
      if (mem_req.cmd != bus_none && is_data_addr(mem_req.addr) && mem_response != '0 &&
          pending_q.size() > 0)
      begin
        if (mem_req.cmd == bus_load)
          loads_in_flight++;
        void'(pending_q.pop_front());
      end
      if (data_req_valid && data_req_ready)
      begin
        pending_q.push_back(data_req);
        if (data_req.is_store)
          shadow[data_req.addr] = data_req.wdata;
        else
        begin
          id_open[data_req.id]    = 1'b1;
          exp_data[data_req.id]   = expected_read(data_req.addr);
          from_store[data_req.id] = shadow.exists(data_req.addr) != 0;
        end
      end
      exp_ready = pending_q.size() < queue_depth;
      if (load_done)
      begin
        k = from_store[load_result.id] ? 6 : 5;
        checks[5]++;
        assert (id_open[load_result.id])
        else report_failure(5, "load_done carried an id that was not in flight");
        checks[k]++;
        assert (load_result.data == exp_data[load_result.id])
        else report_error(k, "load data", exp_data[load_result.id], load_result.data);
        id_open[load_result.id] = 1'b0;
        loads_in_flight--;
      end

      hold_prev   = fetch_valid && !fetch_ready && !redirect_valid;
      bundle_prev = fetch_bundle;
    end
  end

  always @(posedge clock)
  begin
    cycles++;
    if (cycles >= cycle_limit)
    begin
      $display("Timeout after %0d cycles, the tests did not finish", cycles);
      $display("*** FAILED ***");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////
  // Stimulus on the falling edge
  ////////////////////////////////////////////////////////////

  initial
  begin
    int                    total_checks;
    int                    total_errors;
    int                    missing;
    logic [addr_width-1:0] addr;
    logic [data_width-1:0] value;

    rst            = 1'b1;
    redirect_valid = 1'b0;
    redirect_pc    = '0;
    fetch_ready    = 1'b0;
    data_req_valid = 1'b0;
    data_req       = '0;
    next_id        = '0;
    repeat (10) @(negedge clock);
    rst = 1'b0;

    fetch_ready = 1'b1;
    wait_bundles(8);
    finish_test(1);

    fetch_ready = 1'b0;   // Consumer stalls
    while (!fetch_valid)
      @(negedge clock);
    repeat (20) @(negedge clock);
    fetch_ready = 1'b1;
    wait_bundles(bundles + 2);
    finish_test(2);

    for (int i = 0; i < 3; i++)
    begin
      repeat (1 + ($random(seed) & 3)) @(negedge clock);
      redirect_pc    = 64'h400 * 64'(i + 1);
      redirect_valid = 1'b1;
      @(negedge clock);
      redirect_valid = 1'b0;
      wait_bundles(bundles + 2);
    end
    finish_test(3);

    // Mixed traffic while fetch keeps running
    for (int i = 0; i < 8; i++)
    begin
      value = {$random(seed), $random(seed)};
      push_request(i[0] == 1'b0, random_data_addr(), value);
    end
    wait_data_idle();
    finish_test(4);

    for (int i = 0; i < 12; i++)
      push_request(1'b0, random_data_addr(), '0);
    wait_data_idle();
    finish_test(5);

    for (int i = 0; i < 4; i++)
    begin
      addr  = 64'h1_0000_1000 + 64'(i * 8);
      value = {$random(seed), $random(seed)};
      push_request(1'b1, addr, value);
      push_request(1'b0, addr, '0);
    end
    wait_data_idle();
    finish_test(6);

    total_checks = 0;
    total_errors = 0;
    missing      = 0;
    for (int k = 1; k <= 6; k++)
    begin
      total_checks += checks[k];
      total_errors += errors[k];
      if (checks[k] == 0)
        missing++;
    end
    $display("checks %0d, errors %0d, tests without checks %0d",
             total_checks, total_errors, missing);
    if (total_errors == 0 && missing == 0)
      $display("*** PASSED ***");
    else
      $display("*** FAILED ***");
    $finish;
  end

endmodule

// File: tests/tb_memory_model.sv
`timescale 1ns/1ps

module tb_memory_model
  import mem_port_pkg::*;
(
  input  logic                 clock,
  input  logic                 rst,
  input  mem_req_t             mem_req,
  output logic [tag_width-1:0] mem_response,
  output mem_ret_t             mem_ret
);

  integer                seed = 94;
  logic                  accept_ok;          // Drawn one cycle ahead
  logic [num_tags-1:0]   busy;               // Load accepted, tag in use
  logic [num_tags-1:0]   sent;               // Data already on mem_ret
  logic [3:0]            delay [num_tags];
  logic [data_width-1:0] ret_data [num_tags];
  logic [data_width-1:0] store_mem [logic [addr_width-1:0]];
  logic [tag_width-1:0]  free_tag;
  logic [tag_width-1:0]  pick;

  // Lowest free tag, tag 0 is never handed out
  always_comb
  begin
    free_tag = '0;
    for (int t = num_tags-1; t > 0; t--)
      if (!busy[t])
        free_tag = t[tag_width-1:0];
  end

  // Lowest tag whose latency ran out
  always_comb
  begin
    pick = '0;
    for (int t = num_tags-1; t > 0; t--)
      if (busy[t] && !sent[t] && delay[t] == 4'd0)
        pick = t[tag_width-1:0];
  end

  assign mem_response = (mem_req.cmd != bus_none && accept_ok) ? free_tag : '0;

  ////////////////////////////////////////////////////////////
  // Tag bookkeeping and storage
  ////////////////////////////////////////////////////////////

  always @(posedge clock)
  begin
    if (rst)
    begin
      busy      <= '0;
      sent      <= '0;
      accept_ok <= 1'b0;
      mem_ret   <= '0;
    end
    else
    begin
      accept_ok <= ($random(seed) & 3) != 0;   // Reject about one in four
      for (int t = 1; t < num_tags; t++)
        if (busy[t] && delay[t] != 4'd0)
          delay[t] <= delay[t] - 4'd1;
      if (mem_ret.tag != '0)
      begin
        busy[mem_ret.tag] <= 1'b0;   // Free once its return cycle is over
        sent[mem_ret.tag] <= 1'b0;
      end
      mem_ret <= '0;
      if (pick != '0)
      begin
        mem_ret.tag  <= pick;
        mem_ret.data <= ret_data[pick];
        sent[pick]   <= 1'b1;
      end
      if (mem_response != '0 && mem_req.cmd == bus_load)
      begin
        busy[mem_response]  <= 1'b1;
        delay[mem_response] <= 4'($random(seed) & 7);   // 1 to 8 cycles to return
        if (store_mem.exists(mem_req.addr))
          ret_data[mem_response] <= store_mem[mem_req.addr];
        else
          ret_data[mem_response] <= mem_req.addr ^ 64'hA5A5_0000_5A5A_0000;
      end
      if (mem_response != '0 && mem_req.cmd == bus_store)
        store_mem[mem_req.addr] = mem_req.wdata;
    end
  end

endmodule

// File: rtl/mem_port_top.sv
`timescale 1ns/1ps

module mem_port_top
  import mem_port_pkg::*;
(
  input  logic                  clock,
  input  logic                  rst,
  output mem_req_t              mem_req,
  input  logic [tag_width-1:0]  mem_response,
  input  mem_ret_t              mem_ret,
  input  logic                  redirect_valid,
  input  logic [addr_width-1:0] redirect_pc,
  output logic                  fetch_valid,
  output fetch_bundle_t         fetch_bundle,
  input  logic                  fetch_ready,
  input  logic                  data_req_valid,
  input  data_req_t             data_req,
  output logic                  data_req_ready,
  output logic                  load_done,
  output load_result_t          load_result
);

  mem_req_t             fetch_req;
  mem_req_t             data_mem_req;
  logic [tag_width-1:0] fetch_accept_tag;
  logic [tag_width-1:0] data_accept_tag;
  mem_ret_t             fetch_ret;
  mem_ret_t             data_ret;

  ////////////////////////////////////////////////////////////
  // Requesters
  ////////////////////////////////////////////////////////////

  inst_fetch_unit inst_fetch_unit_inst (
    .clock            (clock),
    .rst              (rst),
    .redirect_valid   (redirect_valid),
    .redirect_pc      (redirect_pc),
    .fetch_req        (fetch_req),
    .fetch_accept_tag (fetch_accept_tag),
    .fetch_ret        (fetch_ret),
    .fetch_valid      (fetch_valid),
    .fetch_bundle     (fetch_bundle),
    .fetch_ready      (fetch_ready)
  );

  data_request_queue data_request_queue_inst (
    .clock           (clock),
    .rst             (rst),
    .data_req_valid  (data_req_valid),
    .data_req        (data_req),
    .data_req_ready  (data_req_ready),
    .data_mem_req    (data_mem_req),
    .data_accept_tag (data_accept_tag),
    .data_ret        (data_ret),
    .load_done       (load_done),
    .load_result     (load_result)
  );

  // Shared memory port
  mem_bus_arbiter mem_bus_arbiter_inst (
    .clock            (clock),
    .rst              (rst),
    .fetch_req        (fetch_req),
    .data_mem_req     (data_mem_req),
    .fetch_accept_tag (fetch_accept_tag),
    .data_accept_tag  (data_accept_tag),
    .mem_req          (mem_req),
    .mem_response     (mem_response),
    .mem_ret          (mem_ret),
    .fetch_ret        (fetch_ret),
    .data_ret         (data_ret)
  );

endmodule

// File: rtl/mem_bus_arbiter.sv
`timescale 1ns/1ps

module mem_bus_arbiter
  import mem_port_pkg::*;
(
  input  logic                 clock,
  input  logic                 rst,
  input  mem_req_t             fetch_req,
  input  mem_req_t             data_mem_req,
  output logic [tag_width-1:0] fetch_accept_tag,
  output logic [tag_width-1:0] data_accept_tag,
  output mem_req_t             mem_req,
  input  logic [tag_width-1:0] mem_response,
  input  mem_ret_t             mem_ret,
  output mem_ret_t             fetch_ret,
  output mem_ret_t             data_ret
);

  logic                data_sel;
  logic                load_accept;
  logic                ret_valid;
  logic [num_tags-1:0] owner_data;   // 1 means the data side owns the tag
  logic [num_tags-1:0] tag_live;     // Loads accepted and not yet returned

  ////////////////////////////////////////////////////////////
  // Command path, data side first
  ////////////////////////////////////////////////////////////

  assign data_sel = data_mem_req.cmd != bus_none;
  assign mem_req  = data_sel ? data_mem_req : fetch_req;

  assign data_accept_tag  = data_sel ? mem_response : '0;
  assign fetch_accept_tag = data_sel ? '0 : mem_response;

  assign load_accept = (mem_req.cmd == bus_load) && (mem_response != '0);
  assign ret_valid   = mem_ret.tag != '0;

  // Return steering by owner
  always_comb
  begin
    fetch_ret      = mem_ret;
    data_ret       = mem_ret;
    fetch_ret.tag  = (ret_valid && !owner_data[mem_ret.tag]) ? mem_ret.tag : '0;
    data_ret.tag   = (ret_valid && owner_data[mem_ret.tag]) ? mem_ret.tag : '0;
  end

  ////////////////////////////////////////////////////////////
  // Tag tables
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clock)
  begin
    if (load_accept)
      owner_data[mem_response] <= data_sel;
  end

  always_ff @(posedge clock)
  begin
    if (rst)
      tag_live <= '0;
    else
    begin
      if (ret_valid)
        tag_live[mem_ret.tag] <= 1'b0;
      if (load_accept)
        tag_live[mem_response] <= 1'b1;   // Reuse wins over a same-cycle return
    end
  end

  // Memory must only return tags it handed out for loads
  ret_tag_issued: assert property (@(posedge clock) disable iff (rst)
    ret_valid |-> tag_live[mem_ret.tag]);

endmodule

// File: rtl/data_request_queue.sv
`timescale 1ns/1ps

module data_request_queue
  import mem_port_pkg::*;
(
  input  logic                 clock,
  input  logic                 rst,
  input  logic                 data_req_valid,
  input  data_req_t            data_req,
  output logic                 data_req_ready,
  output mem_req_t             data_mem_req,
  input  logic [tag_width-1:0] data_accept_tag,
  input  mem_ret_t             data_ret,
  output logic                 load_done,
  output load_result_t         load_result
);

  data_req_t                  fifo_mem [queue_depth];
  logic [queue_ptr_width-1:0] wr_ptr;
  logic [queue_ptr_width-1:0] rd_ptr;
  logic [queue_ptr_width:0]   count;
  logic [queue_ptr_width:0]   count_next;
  data_req_t                  head;
  logic                       push;
  logic                       pop;
  logic                       issue_ok;

  logic [load_slots-1:0] slot_valid;
  logic [tag_width-1:0]  slot_tag [load_slots];
  logic [id_width-1:0]   slot_id [load_slots];
  logic [load_slots-1:0] slot_hit;
  logic [load_slots-1:0] free_vec;
  logic [load_slots-1:0] place;      // One-hot slot taking the new load
  logic [id_width-1:0]   hit_id;

  ////////////////////////////////////////////////////////////
  // Issue from the FIFO head
  ////////////////////////////////////////////////////////////

  assign head     = fifo_mem[rd_ptr];
  assign push     = data_req_valid && data_req_ready;
  assign free_vec = ~slot_valid;
  assign issue_ok = (count != '0) && (head.is_store || (free_vec != '0));   // Stores need no slot

  always_comb
  begin
    data_mem_req.cmd = bus_none;
    if (issue_ok)
      data_mem_req.cmd = head.is_store ? bus_store : bus_load;
    data_mem_req.addr  = head.addr;
    data_mem_req.wdata = head.wdata;
  end

  assign pop        = (data_mem_req.cmd != bus_none) && (data_accept_tag != '0);
  assign count_next = count + (queue_ptr_width+1)'(push) - (queue_ptr_width+1)'(pop);
  assign place      = (pop && !head.is_store) ? (free_vec & (~free_vec + 1'b1)) : '0;

  // Match returns against the outstanding loads
  always_comb
  begin
    hit_id = '0;
    for (int i = 0; i < load_slots; i++)
    begin
      slot_hit[i] = slot_valid[i] && (data_ret.tag != '0) && (slot_tag[i] == data_ret.tag);
      if (slot_hit[i])
        hit_id = slot_id[i];
    end
  end

  ////////////////////////////////////////////////////////////
  // State
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clock)
  begin
    if (rst)
    begin
      wr_ptr         <= '0;
      rd_ptr         <= '0;
      count          <= '0;
      data_req_ready <= 1'b0;
      slot_valid     <= '0;
      load_done      <= 1'b0;
    end
    else
    begin
      if (push)
        wr_ptr <= wr_ptr + 1'b1;
      if (pop)
        rd_ptr <= rd_ptr + 1'b1;
      count          <= count_next;
      data_req_ready <= count_next < queue_depth;
      for (int i = 0; i < load_slots; i++)
      begin
        if (slot_hit[i])
          slot_valid[i] <= 1'b0;
        else if (place[i])
          slot_valid[i] <= 1'b1;
      end
      load_done <= |slot_hit;   // Pulse, no back-pressure
    end
  end

  always_ff @(posedge clock)
  begin
    if (push)
      fifo_mem[wr_ptr] <= data_req;
    for (int i = 0; i < load_slots; i++)
    begin
      if (place[i])
      begin
        slot_tag[i] <= data_accept_tag;
        slot_id[i]  <= head.id;
      end
    end
    if (|slot_hit)
    begin
      load_result.id   <= hit_id;
      load_result.data <= data_ret.data;
    end
  end

  // Arbiter steering plus memory tag reuse must keep slots distinct
  one_slot_per_tag: assert property (@(posedge clock) disable iff (rst)
    $onehot0(slot_hit));

endmodule

// File: rtl/inst_fetch_unit.sv
`timescale 1ns/1ps

module inst_fetch_unit
  import mem_port_pkg::*;
(
  input  logic                  clock,
  input  logic                  rst,
  input  logic                  redirect_valid,
  input  logic [addr_width-1:0] redirect_pc,
  output mem_req_t              fetch_req,
  input  logic [tag_width-1:0]  fetch_accept_tag,
  input  mem_ret_t              fetch_ret,
  output logic                  fetch_valid,
  output fetch_bundle_t         fetch_bundle,
  input  logic                  fetch_ready
);

  logic [addr_width-1:0] pc;
  logic                  req_valid;   // Load for pc is on the bus
  logic                  waiting;     // Accepted, data not back yet
  logic [tag_width-1:0]  out_tag;
  logic                  stale;       // Outstanding tag belongs to an old path
  logic                  accepted;
  logic                  returned;
  logic                  transfer;
  logic                  can_issue;

  assign accepted  = req_valid && (fetch_accept_tag != '0);
  assign returned  = waiting && (fetch_ret.tag != '0) && (fetch_ret.tag == out_tag);
  assign transfer  = fetch_valid && fetch_ready;
  assign can_issue = !req_valid && !waiting && !fetch_valid;

  // Rejected commands stay up until memory takes them
  assign fetch_req.cmd   = req_valid ? bus_load : bus_none;
  assign fetch_req.addr  = pc;
  assign fetch_req.wdata = '0;

  ////////////////////////////////////////////////////////////
  // Control
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clock)
  begin
    if (rst)
    begin
      pc          <= reset_pc;
      req_valid   <= 1'b0;
      waiting     <= 1'b0;
      stale       <= 1'b0;
      fetch_valid <= 1'b0;
    end
    else
    begin
      if (accepted)
        req_valid <= 1'b0;
      else if (can_issue)
        req_valid <= 1'b1;

      if (accepted)
        waiting <= 1'b1;
      else if (returned)
        waiting <= 1'b0;

      // A redirect orphans whatever tag is in flight
      if (accepted)
        stale <= redirect_valid;
      else if (returned)
        stale <= 1'b0;
      else if (redirect_valid && waiting)
        stale <= 1'b1;

      if (redirect_valid)
        fetch_valid <= 1'b0;
      else if (returned && !stale)
        fetch_valid <= 1'b1;
      else if (transfer)
        fetch_valid <= 1'b0;

      if (redirect_valid)
        pc <= redirect_pc;
      else if (transfer)
        pc <= pc + fetch_stride;   // Next doubleword
    end
  end

  ////////////////////////////////////////////////////////////
  // Tag and output register
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clock)
  begin
    if (accepted)
      out_tag <= fetch_accept_tag;
    if (returned && !stale && !redirect_valid)
    begin
      fetch_bundle.pc         <= pc;
      fetch_bundle.word.dword <= fetch_ret.data;
    end
  end

  // Consumer must see the same bundle until it takes it
  bundle_held: assert property (@(posedge clock) disable iff (rst)
    fetch_valid && !fetch_ready && !redirect_valid |=> fetch_valid && $stable(fetch_bundle));

endmodule

// File: rtl/mem_port_pkg.sv
package mem_port_pkg;

  ////////////////////////////////////////////////////////////
  // Sizes
  ////////////////////////////////////////////////////////////

  localparam int addr_width      = 64;
  localparam int data_width      = 64;
  localparam int tag_width       = 4;   // Tag 0 means rejected or no data
  localparam int num_tags        = 16;
  localparam int queue_depth     = 4;
  localparam int queue_ptr_width = $clog2(queue_depth);
  localparam int load_slots      = 2;
  localparam int id_width        = 4;

  localparam logic [addr_width-1:0] fetch_stride = 8;   // One doubleword per fetch
  localparam logic [addr_width-1:0] reset_pc     = '0;

  ////////////////////////////////////////////////////////////
  // Memory bus
  ////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {
    bus_none  = 2'd0,
    bus_load  = 2'd1,
    bus_store = 2'd2
  } bus_cmd_t;

  // Fetch sees two instructions, data side one doubleword
  typedef union packed {
    logic [data_width-1:0]                dword;
    logic [1:0][data_width/2-1:0]         inst;   // inst[0] is the lower address
  } mem_word_u;

  typedef struct packed {
    bus_cmd_t              cmd;
    logic [addr_width-1:0] addr;
    logic [data_width-1:0] wdata;
  } mem_req_t;

  typedef struct packed {
    logic [tag_width-1:0]  tag;   // Nonzero marks valid data
    logic [data_width-1:0] data;
  } mem_ret_t;

  ////////////////////////////////////////////////////////////
  // Requester side
  ////////////////////////////////////////////////////////////

  typedef struct packed {
    logic [addr_width-1:0] pc;
    mem_word_u             word;
  } fetch_bundle_t;

  typedef struct packed {
    logic                  is_store;
    logic [id_width-1:0]   id;
    logic [addr_width-1:0] addr;
    logic [data_width-1:0] wdata;
  } data_req_t;

  typedef struct packed {
    logic [id_width-1:0]   id;
    logic [data_width-1:0] data;
  } load_result_t;

endpackage
